// ==== Makefile ====
# Verilator flow for the UART peripheral

TOP = uartTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

# pass only when the simulation prints the pass line
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
verilog/uartPkg.sv
verilog/hostPkg.sv
verilog/baudTickGen.sv
verilog/syncFifo.sv
verilog/uartTx.sv
verilog/uartRx.sv
verilog/uartPeripheral.sv
verif/uartTb.sv

// ==== verif/uartTb.sv ====
// UART peripheral testbench
`timescale 1ns/1ns

module uartTb;

	localparam int bitClocks = uartPkg::oversample * uartPkg::tickDivisor;  // 64
	localparam int frameClocks = 10 * bitClocks;                            // start, 8 data, stop
	localparam int frameCount = 56;   // 20 + 1 + 17 + 1 + 17 frames

	logic clk;
	logic reset;
	logic cmdValid;
	logic [hostPkg::cmdLen-1:0] cmdCode;
	logic [7:0] wrData;
	logic [7:0] rdData;
	logic rdValid;
	logic txd;
	logic rxd;
	logic loopback;     // rxd source, txd or hand-built frames
	logic lineDrive;    // line level in direct mode
	logic readStrobe;

	string testName;
	logic [7:0] sent [$];   // scoreboard, bytes due back in order
	logic [7:0] status;
	logic [7:0] txByte;
	int i;
	int bitIdx;
	int cycles;
	int polls;

	uartPeripheral dut (.clk(clk), .reset(reset), .cmdValid(cmdValid), .cmdCode(cmdCode),
		.wrData(wrData), .rdData(rdData), .rdValid(rdValid), .txd(txd), .rxd(rxd));

	assign rxd = loopback ? txd : lineDrive;
	assign readStrobe = cmdValid &&
		(cmdCode == hostPkg::cmdUartRd || cmdCode == hostPkg::cmdUartStat);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	////////////////////////////////////////
	// reporting and checks
	////////////////////////////////////////

	task automatic abortRun(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkEqual(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected)
		else
			abortRun($sformatf("ERROR %s: %s expected %02h actual %02h",
				testName, what, expected, actual));
	endtask

	// expected status byte, upper three bits zero
	function automatic logic [7:0] packStatus(input logic rxEmpty, input logic txFull,
		input logic frameErr, input logic overrun, input logic txIdle);
		logic [7:0] value;
		value = 8'h00;
		value[hostPkg::statRxEmpty] = rxEmpty;
		value[hostPkg::statTxFull] = txFull;
		value[hostPkg::statFrameErr] = frameErr;
		value[hostPkg::statOverrun] = overrun;
		value[hostPkg::statTxIdle] = txIdle;
		return value;
	endfunction

	// answer one clock after rd or stat, never after a write
	assert property (@(posedge clk) disable iff (reset) readStrobe |=> rdValid)
		else abortRun("rdValid did not follow a read or status command");
	assert property (@(posedge clk) disable iff (reset) !readStrobe |=> !rdValid)
		else abortRun("rdValid pulsed without a read or status command");
	assert property (@(posedge clk) reset |-> (txd && !rdValid))
		else abortRun("txd low or rdValid high while in reset");

	////////////////////////////////////////
	// processor side tasks
	////////////////////////////////////////

	// strobe for one clock, returns on the falling edge where rdValid is due
	task automatic sendCommand(input logic [hostPkg::cmdLen-1:0] code, input logic [7:0] data);
		@(negedge clk);
		cmdValid = 1'b1;
		cmdCode = code;
		wrData = data;
		@(negedge clk);
		cmdValid = 1'b0;
	endtask

	task automatic writeByte(input logic [7:0] data);
		sendCommand(hostPkg::cmdUartWr, data);
		sent.push_back(data);   // expected back via the line
	endtask

	task automatic readStatus(output logic [7:0] value);
		sendCommand(hostPkg::cmdUartStat, 8'h00);
		value = rdData;
	endtask

	task automatic waitTxIdle();
		logic [7:0] stat;
		readStatus(stat);
		while (!stat[hostPkg::statTxIdle])
			readStatus(stat);
	endtask

	// poll until a byte is waiting, then pop it and compare
	task automatic receiveAndCheck(input logic expErr);
		logic [7:0] stat;
		logic [7:0] expected;
		readStatus(stat);
		while (stat[hostPkg::statRxEmpty])
			readStatus(stat);
		checkEqual("frameErr bit", {7'd0, expErr}, {7'd0, stat[hostPkg::statFrameErr]});
		sendCommand(hostPkg::cmdUartRd, 8'h00);
		assert (sent.size() != 0)
		else
			abortRun("a byte came back that was never sent");
		expected = sent.pop_front();
		checkEqual("received byte", expected, rdData);
	endtask

	// hand-built frame on rxd, 64 clocks per bit
	task automatic driveFrame(input logic [7:0] value, input logic stopLevel);
		logic [9:0] frameBits;
		frameBits = {stopLevel, value, 1'b0};   // shifted out LSB first
		for (int n = 0; n < 10; n++)
		begin
			@(negedge clk);
			lineDrive = frameBits[n];
			repeat (bitClocks - 1) @(negedge clk);
		end
		@(negedge clk);
		lineDrive = 1'b1;   // idle again, also after a bad stop bit
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	initial
	begin
		void'($urandom(32'h6e4f_27dc));
		reset = 1'b1;
		cmdValid = 1'b0;
		cmdCode = '0;
		wrData = 8'h00;
		loopback = 1'b1;
		lineDrive = 1'b1;

		testName = "reset";
		repeat (8) @(negedge clk);
		reset = 1'b0;
		checkEqual("txd", 8'h01, {7'd0, txd});
		checkEqual("rdValid", 8'h00, {7'd0, rdValid});
		readStatus(status);
		checkEqual("status", packStatus(1'b1, 1'b0, 1'b0, 1'b0, 1'b1), status);

		testName = "loopback";
		for (i = 0; i < 20; i++)
		begin
			writeByte(8'($urandom()));
			receiveAndCheck(1'b0);
		end

		testName = "tx framing";
		waitTxIdle();
		txByte = 8'($urandom());
		writeByte(txByte);
		cycles = 0;
		while (txd && cycles < 16)   // start bit edge
		begin
			@(negedge clk);
			cycles++;
		end
		assert (cycles <= uartPkg::tickDivisor + 2)
		else
			abortRun($sformatf("ERROR %s: start delay expected at most %0d actual %0d",
				testName, uartPkg::tickDivisor + 2, cycles));
		repeat (bitClocks / 2) @(negedge clk);   // centre of start bit
		checkEqual("start bit", 8'h00, {7'd0, txd});
		for (bitIdx = 0; bitIdx < 8; bitIdx++)
		begin
			repeat (bitClocks) @(negedge clk);
			checkEqual($sformatf("data bit %0d", bitIdx), {7'd0, txByte[bitIdx]}, {7'd0, txd});
		end
		repeat (bitClocks) @(negedge clk);
		checkEqual("stop bit", 8'h01, {7'd0, txd});
		receiveAndCheck(1'b0);

		// one in the shifter, 16 in the fifo, the 18th dropped
		testName = "tx fifo limit";
		waitTxIdle();
		for (i = 0; i < 18; i++)
		begin
			@(negedge clk);
			txByte = 8'($urandom());
			cmdValid = 1'b1;
			cmdCode = hostPkg::cmdUartWr;
			wrData = txByte;
			if (i < 17)
				sent.push_back(txByte);
		end
		@(negedge clk);
		cmdValid = 1'b0;
		readStatus(status);
		checkEqual("status after burst", packStatus(1'b1, 1'b1, 1'b0, 1'b0, 1'b0), status);
		for (i = 0; i < 17; i++)
			receiveAndCheck(1'b0);

		testName = "framing error";
		waitTxIdle();
		loopback = 1'b0;
		txByte = 8'($urandom());
		sent.push_back(txByte);
		driveFrame(txByte, 1'b0);   // stop bit low
		receiveAndCheck(1'b1);

		testName = "rx overrun";
		for (i = 0; i < 17; i++)
		begin
			txByte = 8'($urandom());
			if (i < uartPkg::fifoDepth)
				sent.push_back(txByte);   // 17th lost
			driveFrame(txByte, 1'b1);
		end
		polls = 0;
		readStatus(status);
		while (!status[hostPkg::statOverrun] && polls < bitClocks)
		begin
			readStatus(status);
			polls++;
		end
		checkEqual("status with overrun", packStatus(1'b0, 1'b0, 1'b0, 1'b1, 1'b1), status);
		readStatus(status);
		checkEqual("status after clear", packStatus(1'b0, 1'b0, 1'b0, 1'b0, 1'b1), status);
		for (i = 0; i < uartPkg::fifoDepth; i++)
			receiveAndCheck(1'b0);
		readStatus(status);
		checkEqual("final status", packStatus(1'b1, 1'b0, 1'b0, 1'b0, 1'b1), status);
		checkEqual("bytes left over", 8'h00, 8'(sent.size()));

		$display("test passed");
		$finish;
	end

	// watchdog, twice the frame time of all tests
	initial
	begin
		repeat (frameCount * frameClocks * 2) @(posedge clk);
		abortRun("run timed out before all tests finished");
	end

endmodule

// ==== verilog/baudTickGen.sv ====
// Baud tick generator
`timescale 1ns/1ns

module baudTickGen
#(
	parameter int divisor = uartPkg::tickDivisor  // clocks per tick
)
(
	input  logic clk,
	input  logic reset,
	output logic tick    // one clock wide, once per divisor clocks
);

	// at least one bit, so divisor of 1 still builds
	localparam int cntLen = (divisor > 1) ? $clog2(divisor) : 1;

	logic [cntLen-1:0] cnt;  // wraps at divisor-1

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tick <= (cnt == divisor - 1);  // registered, no glitches downstream
			if (cnt == divisor - 1)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

	// tick spacing, both FSMs count on this
	assert property (@(posedge clk) disable iff (reset)
		(divisor > 1 && tick) |=> !tick);

endmodule

// ==== verilog/hostPkg.sv ====
// Processor side UART encodings

package hostPkg;

	////////////////////////////////////////
	// command codes
	////////////////////////////////////////

	// width of an opcode in the processor's instruction word
	localparam int cmdLen = 5;

	// uart opcodes, same values as the core's opcode map
	localparam logic [cmdLen-1:0] cmdUartRd = 5'd22;    // pop rx byte
	localparam logic [cmdLen-1:0] cmdUartWr = 5'd23;    // push tx byte
	localparam logic [cmdLen-1:0] cmdUartStat = 5'd24;  // read status byte

	////////////////////////////////////////
	// status byte bit positions
	////////////////////////////////////////

	// bits 5 to 7 always read zero
	localparam int statRxEmpty = 0;   // nothing to read
	localparam int statTxFull = 1;    // further writes get dropped
	localparam int statFrameErr = 2;  // head rx entry had a bad stop bit
	localparam int statOverrun = 3;   // rx entry lost, sticky until status read
	localparam int statTxIdle = 4;    // tx fifo empty and line idle

endpackage

// ==== verilog/syncFifo.sv ====
// Show-ahead synchronous FIFO
`timescale 1ns/1ns

module syncFifo
#(
	parameter type payloadType = logic [uartPkg::dataBits-1:0]
)
(
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  payloadType pushData,
	input  logic pop,
	output payloadType popData,   // head entry, valid whenever not empty
	output logic empty,
	output logic full,
	output logic [uartPkg::fifoCountLen-1:0] count
);

	localparam int ptrLen = $clog2(uartPkg::fifoDepth);

	payloadType mem [uartPkg::fifoDepth];  // storage
	logic [ptrLen-1:0] wrPtr;              // next free slot
	logic [ptrLen-1:0] rdPtr;              // head slot
	logic doPush;
	logic doPop;

	// circular increment, depth need not be a power of two
	function automatic logic [ptrLen-1:0] nextPtr(input logic [ptrLen-1:0] ptr);
		if (ptr == ptrLen'(uartPkg::fifoDepth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign doPop = pop && !empty;            // pop on empty ignored
	assign doPush = push && (!full || pop);  // full: only with a pop alongside

	assign empty = (count == '0);
	assign full = (count == uartPkg::fifoDepth);
	assign popData = mem[rdPtr];             // show-ahead read

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;   // none, or push and pop together
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		count <= uartPkg::fifoDepth);
	assert property (@(posedge clk) disable iff (reset)
		!(empty && full));

endmodule

// ==== verilog/uartPeripheral.sv ====
// UART peripheral top level
`timescale 1ns/1ns

module uartPeripheral
(
	input  logic clk,
	input  logic reset,
	input  logic cmdValid,                          // one-clock command strobe
	input  logic [hostPkg::cmdLen-1:0] cmdCode,
	input  logic [uartPkg::dataBits-1:0] wrData,
	output logic [uartPkg::dataBits-1:0] rdData,    // valid with rdValid
	output logic rdValid,                           // one clock after rd or stat
	output logic txd,
	input  logic rxd
);

	logic tick;
	logic txPush, txPop, txEmpty, txFull, txIdle;
	logic [uartPkg::dataBits-1:0] txHead;
	logic [uartPkg::fifoCountLen-1:0] txCount, rxCount;
	uartPkg::rxEntry rxIn, rxHead;
	logic rxPop, rxEmpty, rxFull, rxDrop;
	logic [uartPkg::dataBits-1:0] rxData;
	logic rxFrameErr, rxDoneTick;
	logic rdStrobe, statStrobe, overrun;
	logic [uartPkg::dataBits-1:0] statByte;

	////////////////////////////////////////
	// command decode
	////////////////////////////////////////

	assign txPush = cmdValid && (cmdCode == hostPkg::cmdUartWr);  // dropped when full
	assign rdStrobe = cmdValid && (cmdCode == hostPkg::cmdUartRd);
	assign statStrobe = cmdValid && (cmdCode == hostPkg::cmdUartStat);
	assign rxPop = rdStrobe && !rxEmpty;
	assign rxDrop = rxDoneTick && rxFull && !rxPop;  // no room so the entry is lost

	assign rxIn.rxByte = rxData;
	assign rxIn.frameErr = rxFrameErr;

	always_comb
	begin
		statByte = '0;   // upper bits read zero
		statByte[hostPkg::statRxEmpty] = rxEmpty;
		statByte[hostPkg::statTxFull] = txFull;
		statByte[hostPkg::statFrameErr] = !rxEmpty && rxHead.frameErr;
		statByte[hostPkg::statOverrun] = overrun;
		statByte[hostPkg::statTxIdle] = txIdle && txEmpty;  // whole tx path quiet
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rdValid <= 1'b0;
			overrun <= 1'b0;
		end
		else
		begin
			rdValid <= rdStrobe || statStrobe;
			if (statStrobe)
				overrun <= 1'b0;   // cleared by status read
			if (rxDrop)
				overrun <= 1'b1;   // new loss wins over a clear
		end
	end

	always_ff @(posedge clk)
	begin
		if (rdStrobe)
			rdData <= rxEmpty ? '0 : rxHead.rxByte;
		else if (statStrobe)
			rdData <= statByte;
	end

	baudTickGen tickGen (.clk(clk), .reset(reset), .tick(tick));

	syncFifo #(.payloadType(logic [uartPkg::dataBits-1:0])) txFifo (.clk(clk), .reset(reset),
		.push(txPush), .pushData(wrData), .pop(txPop), .popData(txHead),
		.empty(txEmpty), .full(txFull), .count(txCount));

	syncFifo #(.payloadType(uartPkg::rxEntry)) rxFifo (.clk(clk), .reset(reset),
		.push(rxDoneTick), .pushData(rxIn), .pop(rxPop), .popData(rxHead),
		.empty(rxEmpty), .full(rxFull), .count(rxCount));

	uartTx transmitter (.clk(clk), .reset(reset), .tick(tick), .txStart(!txEmpty),
		.din(txHead), .fifoPop(txPop), .txIdle(txIdle), .tx(txd));

	uartRx receiver (.clk(clk), .reset(reset), .tick(tick), .rx(rxd), .rxData(rxData),
		.frameErr(rxFrameErr), .rxDoneTick(rxDoneTick));

	// write into an empty, idle path is popped on the next clock
	assert property (@(posedge clk) disable iff (reset)
		(txPush && txCount == '0 && txIdle) |=> txPop);
	// a lost entry leaves the full rx fifo untouched
	assert property (@(posedge clk) disable iff (reset)
		rxDrop |=> (rxCount == uartPkg::fifoDepth));

endmodule

// ==== verilog/uartPkg.sv ====
// UART line format definitions

package uartPkg;

	////////////////////////////////////////
	// character format
	////////////////////////////////////////

	localparam int dataBits = 8;      // bits per character, no parity
	localparam int oversample = 16;   // ticks per bit period
	localparam int stopTicks = 16;    // ticks in the stop bit, one stop bit

	// clocks per oversampling tick
	// small for simulation: 64 clocks per bit, 640 per frame
	localparam int tickDivisor = 4;

	////////////////////////////////////////
	// buffering
	////////////////////////////////////////

	localparam int fifoDepth = 16;    // entries per fifo
	localparam int fifoCountLen = 5;  // holds 0 to fifoDepth

	// rx fifo entry, byte kept together with its stop-bit check
	typedef struct packed
	{
		logic [dataBits-1:0] rxByte;  // received character
		logic frameErr;               // stop bit sampled low
	} rxEntry;

	////////////////////////////////////////
	// line FSM states, shared by tx and rx
	////////////////////////////////////////

	typedef enum logic [1:0]
	{
		idle,    // line high, nothing in progress
		start,   // start bit
		data,    // data bits, LSB first
		stop     // stop bit
	} lineState;

endpackage

// ==== verilog/uartRx.sv ====
// UART oversampling receiver
`timescale 1ns/1ns

module uartRx
(
	input  logic clk,
	input  logic reset,
	input  logic tick,                             // oversampling tick
	input  logic rx,                               // async serial line
	output logic [uartPkg::dataBits-1:0] rxData,   // valid with rxDoneTick
	output logic frameErr,                         // stop bit was low
	output logic rxDoneTick                        // one clock per character
);

	localparam int tickLen = $clog2((uartPkg::stopTicks > uartPkg::oversample) ?
		uartPkg::stopTicks : uartPkg::oversample);
	localparam int bitLen = $clog2(uartPkg::dataBits);
	localparam int halfBit = uartPkg::oversample / 2 - 1;  // start bit centre

	uartPkg::lineState stateReg, stateNext;
	logic [tickLen-1:0] sReg, sNext;
	logic [bitLen-1:0] nReg, nNext;
	logic [uartPkg::dataBits-1:0] bReg, bNext;   // assembles LSB first
	logic ferrReg, ferrNext;
	logic doneReg, doneNext;
	logic rxMeta, rxSync;   // two-flop synchronizer
	logic rxLast;           // previous synced level, for edge detect

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
			doneReg <= 1'b0;
			rxMeta <= 1'b1;   // assume idle line
			rxSync <= 1'b1;
			rxLast <= 1'b1;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			doneReg <= doneNext;
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxLast <= rxSync;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
		ferrReg <= ferrNext;
	end

	////////////////////////////////////////
	// receive FSM
	////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		ferrNext = ferrReg;
		doneNext = 1'b0;
		case (stateReg)
			uartPkg::idle:
				if (rxLast && !rxSync)   // falling edge, possible start bit
				begin
					stateNext = uartPkg::start;
					sNext = '0;
				end
			uartPkg::start:
				if (tick)
				begin
					if (sReg == halfBit)
					begin
						// still low at centre: real start bit
						stateNext = rxSync ? uartPkg::idle : uartPkg::data;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::data:
				if (tick)
				begin
					if (sReg == uartPkg::oversample - 1)   // bit centre
					begin
						sNext = '0;
						bNext = {rxSync, bReg[uartPkg::dataBits-1:1]};
						if (nReg == bitLen'(uartPkg::dataBits - 1))
							stateNext = uartPkg::stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::stop:
				if (tick)
				begin
					if (sReg == uartPkg::stopTicks - 1)   // stop bit centre
					begin
						ferrNext = !rxSync;
						doneNext = 1'b1;
						stateNext = uartPkg::idle;
					end
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = uartPkg::idle;
		endcase
	end

	assign rxData = bReg;
	assign frameErr = ferrReg;
	assign rxDoneTick = doneReg;

	assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |=> !rxDoneTick);

endmodule

// ==== verilog/uartTx.sv ====
// UART transmitter
`timescale 1ns/1ns

module uartTx
(
	input  logic clk,
	input  logic reset,
	input  logic tick,                           // oversampling tick
	input  logic txStart,                        // byte waiting in the fifo
	input  logic [uartPkg::dataBits-1:0] din,    // fifo head, show-ahead
	output logic fifoPop,                        // one clock, advances the fifo
	output logic txIdle,
	output logic tx                              // serial line, idles high
);

	localparam int tickLen = $clog2((uartPkg::stopTicks > uartPkg::oversample) ?
		uartPkg::stopTicks : uartPkg::oversample);
	localparam int bitLen = $clog2(uartPkg::dataBits);

	uartPkg::lineState stateReg, stateNext;
	logic [tickLen-1:0] sReg, sNext;              // ticks within a bit
	logic [bitLen-1:0] nReg, nNext;               // data bit index
	logic [uartPkg::dataBits-1:0] bReg, bNext;    // shift register
	logic txReg, txNext;                          // registered line bit
	logic armedReg, armedNext;                    // byte latched, waiting for a tick

	////////////////////////////////////////
	// state registers
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;   // line high out of reset
			armedReg <= 1'b0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
			armedReg <= armedNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		armedNext = armedReg;
		fifoPop = 1'b0;
		case (stateReg)
			uartPkg::idle:
			begin
				txNext = 1'b1;
				if (txStart && !armedReg)  // pop and latch the head right away
				begin
					fifoPop = 1'b1;
					bNext = din;
					armedNext = 1'b1;
				end
				// start bit begins on a tick so it spans a full 16 ticks
				if ((armedReg || txStart) && tick)
				begin
					stateNext = uartPkg::start;
					armedNext = 1'b0;
					sNext = '0;
				end
			end
			uartPkg::start:
			begin
				txNext = 1'b0;
				if (tick)
				begin
					if (sReg == uartPkg::oversample - 1)
					begin
						stateNext = uartPkg::data;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::data:
			begin
				txNext = bReg[0];          // LSB first
				if (tick)
				begin
					if (sReg == uartPkg::oversample - 1)
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == bitLen'(uartPkg::dataBits - 1))
							stateNext = uartPkg::stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::stop:
			begin
				txNext = 1'b1;
				if (tick)
				begin
					if (sReg == uartPkg::stopTicks - 1)
						stateNext = uartPkg::idle;
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = uartPkg::idle;
		endcase
	end

	assign tx = txReg;
	assign txIdle = (stateReg == uartPkg::idle) && !armedReg;

	assert property (@(posedge clk) disable iff (reset)
		fifoPop |-> (stateReg == uartPkg::idle && txStart));
	// line follows the state one clock later
	assert property (@(posedge clk) disable iff (reset)
		(stateReg != uartPkg::start ##1 stateReg == uartPkg::start) |=> !tx);
	assert property (@(posedge clk) disable iff (reset)
		(stateReg == uartPkg::idle) |-> tx);

endmodule
